/* common/mux_consts.svh */
/*
 * memory port mux constants
 * widths of the simplified AXI fields, W routing FIFO depth
 * and the number of requesters sharing the memory port
 */
`ifndef MUX_CONSTS_SVH
`define MUX_CONSTS_SVH

// AXI field widths
`define MUX_ID_W 4
`define MUX_ADDR_W 32
`define MUX_DATA_W 64
`define MUX_LEN_W 8

// writes accepted on AW but not yet finished on W
`define MUX_WFIFO_DEPTH 4

// icache, bypass, dcache
`define MUX_NUM_SRC 3

`endif

/* common/axi_lite_pkg.sv */
/*
 * simplified AXI4 field types
 * only id, addr, len, data, strb and last are carried
 */
`default_nettype none

`include "mux_consts.svh"

package axi_lite_pkg;

  typedef logic [`MUX_ID_W-1:0]     id_t;
  typedef logic [`MUX_ADDR_W-1:0]   addr_t;
  typedef logic [`MUX_DATA_W-1:0]   data_t;
  typedef logic [`MUX_DATA_W/8-1:0] strb_t; // one bit per byte
  typedef logic [`MUX_LEN_W-1:0]    len_t;  // beats minus one

  // shared by AR and AW
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } addr_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

endpackage

`default_nettype wire

/* common/port_pkg.sv */
/*
 * requester encoding of the memory port mux
 * and the transaction ID to requester decode
 */
`default_nettype none

package port_pkg;

  typedef enum logic [1:0] {
    SRC_ICACHE = 2'd0,
    SRC_BYPASS = 2'd1,
    SRC_DCACHE = 2'd2
  } src_e;

  // 0111 -> dcache, 1xxx -> bypass, anything else -> icache
  function automatic src_e src_of_id(input axi_lite_pkg::id_t id);
    src_e src;
    src = SRC_ICACHE;
    if (id == axi_lite_pkg::id_t'(4'b0111)) begin
      src = SRC_DCACHE;
    end else if (id[$bits(axi_lite_pkg::id_t)-1]) begin
      src = SRC_BYPASS; // msb marks uncached traffic
    end
    return src;
  endfunction

endpackage

`default_nettype wire

/* common/axi_bus_if.sv */
/*
 * one simplified AXI4 port
 * address, write data and response channels with valid/ready
 */
`timescale 1ns/1ns
`default_nettype none

interface axi_bus_if;

  // read address
  logic                    ar_valid;
  logic                    ar_ready;
  axi_lite_pkg::addr_chan_t ar;

  // write address
  logic                    aw_valid;
  logic                    aw_ready;
  axi_lite_pkg::addr_chan_t aw;

  // write data
  logic                    w_valid;
  logic                    w_ready;
  axi_lite_pkg::w_chan_t   w;

  // read data
  logic                    r_valid;
  logic                    r_ready;
  axi_lite_pkg::id_t       r_id;
  axi_lite_pkg::data_t     r_data;
  logic                    r_last;

  // write response
  logic                    b_valid;
  logic                    b_ready;
  axi_lite_pkg::id_t       b_id;

  modport master (
    output ar_valid, ar, aw_valid, aw, w_valid, w, r_ready, b_ready,
    input  ar_ready, aw_ready, w_ready,
    input  r_valid, r_id, r_data, r_last, b_valid, b_id
  );

  modport slave (
    input  ar_valid, ar, aw_valid, aw, w_valid, w, r_ready, b_ready,
    output ar_ready, aw_ready, w_ready,
    output r_valid, r_id, r_data, r_last, b_valid, b_id
  );

endinterface

`default_nettype wire

/* source/stream_arbiter.sv */
/*
 * round-robin valid/ready arbiter
 * the grant rotates past the last granted input and is
 * held while the output is offered but not accepted
 */
`timescale 1ns/1ns
`default_nettype none

`include "mux_consts.svh"

module stream_arbiter #(
  parameter int unsigned DATA_W = 32
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic [`MUX_NUM_SRC-1:0][DATA_W-1:0] inp_data_i,
  input  logic [`MUX_NUM_SRC-1:0]              inp_valid_i,
  output logic [`MUX_NUM_SRC-1:0]              inp_ready_o,
  output logic [DATA_W-1:0]                    oup_data_o,
  output logic                                 oup_valid_o,
  input  logic                                 oup_ready_i
);

  localparam int unsigned NumInp = `MUX_NUM_SRC;

  typedef logic [$clog2(NumInp)-1:0] idx_t;

  idx_t last_q;  // last offered input
  idx_t sel;
  logic lock_q;
  logic found;

  // ----------------------------------------
  // grant selection
  // ----------------------------------------
  always_comb begin : rr_search
    int unsigned cand;
    sel   = last_q;
    found = 1'b0;
    cand  = 0;
    if (lock_q) begin
      found = 1'b1; // stalled request keeps the grant
    end else begin
      for (int unsigned i = 0; i < NumInp; i++) begin
        cand = int'(last_q) + 1 + i;
        if (cand >= NumInp) cand = cand - NumInp;
        if (!found && inp_valid_i[cand]) begin
          sel   = idx_t'(cand);
          found = 1'b1;
        end
      end
    end
  end

  assign oup_valid_o = found & inp_valid_i[sel];
  assign oup_data_o  = inp_data_i[sel];

  always_comb begin
    inp_ready_o      = '0;
    inp_ready_o[sel] = oup_valid_o & oup_ready_i; // only the granted input
  end

  // ----------------------------------------
  // pointer and lock
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= idx_t'(NumInp - 1); // input 0 first after reset
      lock_q <= 1'b0;
    end else begin
      lock_q <= oup_valid_o & ~oup_ready_i;
      if (oup_valid_o) begin
        last_q <= sel;
      end
    end
  end

endmodule

`default_nettype wire

/* axi_mux/w_route_fifo.sv */
/*
 * write data routing
 * AXI4 has no write ID, so the source of every accepted AW is queued
 * and W beats are taken from the source at the queue head
 */
`timescale 1ns/1ns
`default_nettype none

`include "mux_consts.svh"

module w_route_fifo (
  input  logic clk_i,
  input  logic rst_ni,
  axi_bus_if.slave  icache_bus,
  axi_bus_if.slave  bypass_bus,
  axi_bus_if.slave  dcache_bus,
  axi_bus_if.master mem_bus,
  output logic full_o
);

  typedef logic [$clog2(`MUX_WFIFO_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(`MUX_WFIFO_DEPTH+1)-1:0] cnt_t;

  port_pkg::src_e fifo_q [`MUX_WFIFO_DEPTH];
  ptr_t           wr_ptr_q, rd_ptr_q;
  cnt_t           count_q;
  port_pkg::src_e aw_src;
  port_pkg::src_e w_sel;
  logic           empty;
  logic           push, pop;
  logic           w_open;   // W may pass at all
  logic           src_valid;

  assign aw_src = port_pkg::src_of_id(mem_bus.aw.id);
  assign empty  = (count_q == '0);
  assign full_o = (count_q == cnt_t'(`MUX_WFIFO_DEPTH));

  assign push = mem_bus.aw_valid & mem_bus.aw_ready;
  // a last beat closes the oldest write, never pop an empty queue
  assign pop  = mem_bus.w_valid & mem_bus.w_ready & mem_bus.w.last & (~empty | push);

  // ----------------------------------------
  // source queue
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (push) fifo_q[wr_ptr_q] <= aw_src;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(`MUX_WFIFO_DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(`MUX_WFIFO_DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ----------------------------------------
  // W channel mux
  // ----------------------------------------
  // empty queue falls through to the AW on the bus right now
  assign w_open = ~empty | mem_bus.aw_valid;
  assign w_sel  = !empty ? fifo_q[rd_ptr_q] :
                  mem_bus.aw_valid ? aw_src : port_pkg::SRC_ICACHE;

  always_comb begin
    icache_bus.w_ready = 1'b0;
    bypass_bus.w_ready = 1'b0;
    dcache_bus.w_ready = 1'b0;
    case (w_sel)
      port_pkg::SRC_BYPASS: begin
        mem_bus.w          = bypass_bus.w;
        src_valid          = bypass_bus.w_valid;
        bypass_bus.w_ready = w_open & mem_bus.w_ready;
      end
      port_pkg::SRC_DCACHE: begin
        mem_bus.w          = dcache_bus.w;
        src_valid          = dcache_bus.w_valid;
        dcache_bus.w_ready = w_open & mem_bus.w_ready;
      end
      default: begin // icache never writes in practice
        mem_bus.w          = icache_bus.w;
        src_valid          = icache_bus.w_valid;
        icache_bus.w_ready = w_open & mem_bus.w_ready;
      end
    endcase
  end

  assign mem_bus.w_valid = w_open & src_valid;

endmodule

`default_nettype wire

/* axi_mux/resp_router.sv */
/*
 * response routing
 * R and B are broadcast, valid goes only to the requester
 * that owns the response ID
 */
`timescale 1ns/1ns
`default_nettype none

module resp_router (
  axi_bus_if.slave  icache_bus,
  axi_bus_if.slave  bypass_bus,
  axi_bus_if.slave  dcache_bus,
  axi_bus_if.master mem_bus
);

  port_pkg::src_e r_src;
  port_pkg::src_e b_src;

  assign r_src = port_pkg::src_of_id(mem_bus.r_id);
  assign b_src = port_pkg::src_of_id(mem_bus.b_id);

  // ----------------------------------------
  // R channel
  // ----------------------------------------
  assign icache_bus.r_id   = mem_bus.r_id;
  assign bypass_bus.r_id   = mem_bus.r_id;
  assign dcache_bus.r_id   = mem_bus.r_id;
  assign icache_bus.r_data = mem_bus.r_data;
  assign bypass_bus.r_data = mem_bus.r_data;
  assign dcache_bus.r_data = mem_bus.r_data;
  assign icache_bus.r_last = mem_bus.r_last;
  assign bypass_bus.r_last = mem_bus.r_last;
  assign dcache_bus.r_last = mem_bus.r_last;

  assign icache_bus.r_valid = mem_bus.r_valid & (r_src == port_pkg::SRC_ICACHE);
  assign bypass_bus.r_valid = mem_bus.r_valid & (r_src == port_pkg::SRC_BYPASS);
  assign dcache_bus.r_valid = mem_bus.r_valid & (r_src == port_pkg::SRC_DCACHE);

  assign mem_bus.r_ready = (r_src == port_pkg::SRC_BYPASS) ? bypass_bus.r_ready :
                           (r_src == port_pkg::SRC_DCACHE) ? dcache_bus.r_ready :
                                                             icache_bus.r_ready;

  // ----------------------------------------
  // B channel
  // ----------------------------------------
  assign icache_bus.b_id = mem_bus.b_id;
  assign bypass_bus.b_id = mem_bus.b_id;
  assign dcache_bus.b_id = mem_bus.b_id;

  assign icache_bus.b_valid = mem_bus.b_valid & (b_src == port_pkg::SRC_ICACHE);
  assign bypass_bus.b_valid = mem_bus.b_valid & (b_src == port_pkg::SRC_BYPASS);
  assign dcache_bus.b_valid = mem_bus.b_valid & (b_src == port_pkg::SRC_DCACHE);

  assign mem_bus.b_ready = (b_src == port_pkg::SRC_BYPASS) ? bypass_bus.b_ready :
                           (b_src == port_pkg::SRC_DCACHE) ? dcache_bus.b_ready :
                                                             icache_bus.b_ready;

endmodule

`default_nettype wire

/* axi_mux/mem_port_mux.sv */
/*
 * memory port multiplexer of the L1 cache subsystem
 * icache, bypass and dcache share one simplified AXI4 master port
 * address channels are arbitrated round-robin, W follows AW order,
 * responses are routed back by transaction ID
 */
`timescale 1ns/1ns
`default_nettype none

module mem_port_mux (
  input  logic clk_i,
  input  logic rst_ni,
  // icache
  input  logic ic_ar_valid_i, ic_aw_valid_i, ic_w_valid_i, ic_r_ready_i, ic_b_ready_i,
  input  axi_lite_pkg::addr_chan_t ic_ar_i, ic_aw_i,
  input  axi_lite_pkg::w_chan_t    ic_w_i,
  output logic ic_ar_ready_o, ic_aw_ready_o, ic_w_ready_o, ic_r_valid_o, ic_r_last_o,
  output logic ic_b_valid_o,
  output axi_lite_pkg::id_t        ic_r_id_o, ic_b_id_o,
  output axi_lite_pkg::data_t      ic_r_data_o,
  // uncached bypass
  input  logic by_ar_valid_i, by_aw_valid_i, by_w_valid_i, by_r_ready_i, by_b_ready_i,
  input  axi_lite_pkg::addr_chan_t by_ar_i, by_aw_i,
  input  axi_lite_pkg::w_chan_t    by_w_i,
  output logic by_ar_ready_o, by_aw_ready_o, by_w_ready_o, by_r_valid_o, by_r_last_o,
  output logic by_b_valid_o,
  output axi_lite_pkg::id_t        by_r_id_o, by_b_id_o,
  output axi_lite_pkg::data_t      by_r_data_o,
  // write-back dcache
  input  logic dc_ar_valid_i, dc_aw_valid_i, dc_w_valid_i, dc_r_ready_i, dc_b_ready_i,
  input  axi_lite_pkg::addr_chan_t dc_ar_i, dc_aw_i,
  input  axi_lite_pkg::w_chan_t    dc_w_i,
  output logic dc_ar_ready_o, dc_aw_ready_o, dc_w_ready_o, dc_r_valid_o, dc_r_last_o,
  output logic dc_b_valid_o,
  output axi_lite_pkg::id_t        dc_r_id_o, dc_b_id_o,
  output axi_lite_pkg::data_t      dc_r_data_o,
  // memory
  output logic mem_ar_valid_o, mem_aw_valid_o, mem_w_valid_o, mem_r_ready_o, mem_b_ready_o,
  output axi_lite_pkg::addr_chan_t mem_ar_o, mem_aw_o,
  output axi_lite_pkg::w_chan_t    mem_w_o,
  input  logic mem_ar_ready_i, mem_aw_ready_i, mem_w_ready_i, mem_r_valid_i, mem_r_last_i,
  input  logic mem_b_valid_i,
  input  axi_lite_pkg::id_t        mem_r_id_i, mem_b_id_i,
  input  axi_lite_pkg::data_t      mem_r_data_i
);

  axi_bus_if icache_bus ();
  axi_bus_if bypass_bus ();
  axi_bus_if dcache_bus ();
  axi_bus_if mem_bus ();

  logic [2:0] ar_gnt;       // index 0 icache, 1 bypass, 2 dcache
  logic [2:0] aw_gnt;
  logic       aw_arb_valid;
  logic       aw_arb_ready;
  logic       w_full;

  // ----------------------------------------
  // requester ports
  // ----------------------------------------
  assign icache_bus.ar_valid = ic_ar_valid_i;
  assign icache_bus.ar       = ic_ar_i;
  assign icache_bus.aw_valid = ic_aw_valid_i;
  assign icache_bus.aw       = ic_aw_i;
  assign icache_bus.w_valid  = ic_w_valid_i;
  assign icache_bus.w        = ic_w_i;
  assign icache_bus.r_ready  = ic_r_ready_i;
  assign icache_bus.b_ready  = ic_b_ready_i;
  assign icache_bus.ar_ready = ar_gnt[0];
  assign icache_bus.aw_ready = aw_gnt[0];
  assign ic_ar_ready_o = icache_bus.ar_ready;
  assign ic_aw_ready_o = icache_bus.aw_ready;
  assign ic_w_ready_o  = icache_bus.w_ready;
  assign ic_r_valid_o  = icache_bus.r_valid;
  assign ic_r_id_o     = icache_bus.r_id;
  assign ic_r_data_o   = icache_bus.r_data;
  assign ic_r_last_o   = icache_bus.r_last;
  assign ic_b_valid_o  = icache_bus.b_valid;
  assign ic_b_id_o     = icache_bus.b_id;

  assign bypass_bus.ar_valid = by_ar_valid_i;
  assign bypass_bus.ar       = by_ar_i;
  assign bypass_bus.aw_valid = by_aw_valid_i;
  assign bypass_bus.aw       = by_aw_i;
  assign bypass_bus.w_valid  = by_w_valid_i;
  assign bypass_bus.w        = by_w_i;
  assign bypass_bus.r_ready  = by_r_ready_i;
  assign bypass_bus.b_ready  = by_b_ready_i;
  assign bypass_bus.ar_ready = ar_gnt[1];
  assign bypass_bus.aw_ready = aw_gnt[1];
  assign by_ar_ready_o = bypass_bus.ar_ready;
  assign by_aw_ready_o = bypass_bus.aw_ready;
  assign by_w_ready_o  = bypass_bus.w_ready;
  assign by_r_valid_o  = bypass_bus.r_valid;
  assign by_r_id_o     = bypass_bus.r_id;
  assign by_r_data_o   = bypass_bus.r_data;
  assign by_r_last_o   = bypass_bus.r_last;
  assign by_b_valid_o  = bypass_bus.b_valid;
  assign by_b_id_o     = bypass_bus.b_id;

  assign dcache_bus.ar_valid = dc_ar_valid_i;
  assign dcache_bus.ar       = dc_ar_i;
  assign dcache_bus.aw_valid = dc_aw_valid_i;
  assign dcache_bus.aw       = dc_aw_i;
  assign dcache_bus.w_valid  = dc_w_valid_i;
  assign dcache_bus.w        = dc_w_i;
  assign dcache_bus.r_ready  = dc_r_ready_i;
  assign dcache_bus.b_ready  = dc_b_ready_i;
  assign dcache_bus.ar_ready = ar_gnt[2];
  assign dcache_bus.aw_ready = aw_gnt[2];
  assign dc_ar_ready_o = dcache_bus.ar_ready;
  assign dc_aw_ready_o = dcache_bus.aw_ready;
  assign dc_w_ready_o  = dcache_bus.w_ready;
  assign dc_r_valid_o  = dcache_bus.r_valid;
  assign dc_r_id_o     = dcache_bus.r_id;
  assign dc_r_data_o   = dcache_bus.r_data;
  assign dc_r_last_o   = dcache_bus.r_last;
  assign dc_b_valid_o  = dcache_bus.b_valid;
  assign dc_b_id_o     = dcache_bus.b_id;

  // ----------------------------------------
  // memory port
  // ----------------------------------------
  assign mem_ar_valid_o = mem_bus.ar_valid;
  assign mem_ar_o       = mem_bus.ar;
  assign mem_aw_valid_o = mem_bus.aw_valid;
  assign mem_aw_o       = mem_bus.aw;
  assign mem_w_valid_o  = mem_bus.w_valid;
  assign mem_w_o        = mem_bus.w;
  assign mem_r_ready_o  = mem_bus.r_ready;
  assign mem_b_ready_o  = mem_bus.b_ready;
  assign mem_bus.ar_ready = mem_ar_ready_i;
  assign mem_bus.aw_ready = mem_aw_ready_i;
  assign mem_bus.w_ready  = mem_w_ready_i;
  assign mem_bus.r_valid  = mem_r_valid_i;
  assign mem_bus.r_id     = mem_r_id_i;
  assign mem_bus.r_data   = mem_r_data_i;
  assign mem_bus.r_last   = mem_r_last_i;
  assign mem_bus.b_valid  = mem_b_valid_i;
  assign mem_bus.b_id     = mem_b_id_i;

  // ----------------------------------------
  // address arbitration
  // ----------------------------------------
  stream_arbiter #(
    .DATA_W ($bits(axi_lite_pkg::addr_chan_t))
  ) u_ar_arb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .inp_data_i  ({dcache_bus.ar, bypass_bus.ar, icache_bus.ar}),
    .inp_valid_i ({dcache_bus.ar_valid, bypass_bus.ar_valid, icache_bus.ar_valid}),
    .inp_ready_o (ar_gnt),
    .oup_data_o  (mem_bus.ar),
    .oup_valid_o (mem_bus.ar_valid),
    .oup_ready_i (mem_bus.ar_ready)
  );

  stream_arbiter #(
    .DATA_W ($bits(axi_lite_pkg::addr_chan_t))
  ) u_aw_arb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .inp_data_i  ({dcache_bus.aw, bypass_bus.aw, icache_bus.aw}),
    .inp_valid_i ({dcache_bus.aw_valid, bypass_bus.aw_valid, icache_bus.aw_valid}),
    .inp_ready_o (aw_gnt),
    .oup_data_o  (mem_bus.aw),
    .oup_valid_o (aw_arb_valid),
    .oup_ready_i (aw_arb_ready)
  );

  // no new write while every W routing slot is taken
  assign mem_bus.aw_valid = aw_arb_valid & ~w_full;
  assign aw_arb_ready     = mem_bus.aw_ready & ~w_full;

  w_route_fifo u_w_route (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .icache_bus (icache_bus),
    .bypass_bus (bypass_bus),
    .dcache_bus (dcache_bus),
    .mem_bus    (mem_bus),
    .full_o     (w_full)
  );

  resp_router u_resp_router (
    .icache_bus (icache_bus),
    .bypass_bus (bypass_bus),
    .dcache_bus (dcache_bus),
    .mem_bus    (mem_bus)
  );

endmodule

`default_nettype wire

/* sim/tb_mem_port_mux.sv */
/*
 * testbench of the memory port mux
 * LFSR-driven requesters and memory model, immediate assertions
 * check arbitration, write order and response routing
 */
`timescale 1ns/1ns
`default_nettype none

`include "mux_consts.svh"

module tb_mem_port_mux;

  localparam int CYCLE_LIMIT = 4000;

  logic clk_i = 1'b0;
  logic rst_ni;
  // index 0 icache, 1 bypass, 2 dcache
  logic [2:0] ar_vld, ar_rdy, aw_vld, aw_rdy, w_vld, w_rdy, r_rdy_in, b_rdy_in;
  logic [2:0] r_vld, r_last, b_vld;
  axi_lite_pkg::addr_chan_t ar_pl [3];
  axi_lite_pkg::addr_chan_t aw_pl [3];
  axi_lite_pkg::w_chan_t    w_pl [3];
  axi_lite_pkg::id_t        r_id [3];
  axi_lite_pkg::id_t        b_id [3];
  axi_lite_pkg::data_t      r_data [3];
  // memory side
  logic mem_ar_valid_o, mem_aw_valid_o, mem_w_valid_o, mem_r_ready_o, mem_b_ready_o;
  axi_lite_pkg::addr_chan_t mem_ar_o, mem_aw_o;
  axi_lite_pkg::w_chan_t    mem_w_o;
  logic mem_ar_rdy, mem_aw_rdy, mem_w_rdy, mem_r_vld, mem_r_lst, mem_b_vld;
  axi_lite_pkg::id_t   mem_r_id, mem_b_id;
  axi_lite_pkg::data_t mem_r_dat;

  // stimulus control
  logic [2:0] ar_en, aw_en;
  logic       ar_keep, w_hold, resp_en;
  int         phase;
  logic [31:0] lfsr_q = 32'h7cb8_77ae;
  int unsigned pend_len [3][$];  // accepted write lengths per requester
  int          beats_left [3];
  int          wq [$];           // expected W order
  int          req_ar_cnt [3], mem_ar_cnt [3], req_aw_cnt [3], mem_aw_cnt [3];
  int          skip [3];
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  always #5 clk_i = ~clk_i;

  mem_port_mux u_mem_port_mux (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .ic_ar_valid_i (ar_vld[0]), .ic_aw_valid_i (aw_vld[0]), .ic_w_valid_i (w_vld[0]),
    .ic_r_ready_i (r_rdy_in[0]), .ic_b_ready_i (b_rdy_in[0]),
    .ic_ar_i (ar_pl[0]), .ic_aw_i (aw_pl[0]), .ic_w_i (w_pl[0]),
    .ic_ar_ready_o (ar_rdy[0]), .ic_aw_ready_o (aw_rdy[0]), .ic_w_ready_o (w_rdy[0]),
    .ic_r_valid_o (r_vld[0]), .ic_r_last_o (r_last[0]), .ic_b_valid_o (b_vld[0]),
    .ic_r_id_o (r_id[0]), .ic_b_id_o (b_id[0]), .ic_r_data_o (r_data[0]),
    .by_ar_valid_i (ar_vld[1]), .by_aw_valid_i (aw_vld[1]), .by_w_valid_i (w_vld[1]),
    .by_r_ready_i (r_rdy_in[1]), .by_b_ready_i (b_rdy_in[1]),
    .by_ar_i (ar_pl[1]), .by_aw_i (aw_pl[1]), .by_w_i (w_pl[1]),
    .by_ar_ready_o (ar_rdy[1]), .by_aw_ready_o (aw_rdy[1]), .by_w_ready_o (w_rdy[1]),
    .by_r_valid_o (r_vld[1]), .by_r_last_o (r_last[1]), .by_b_valid_o (b_vld[1]),
    .by_r_id_o (r_id[1]), .by_b_id_o (b_id[1]), .by_r_data_o (r_data[1]),
    .dc_ar_valid_i (ar_vld[2]), .dc_aw_valid_i (aw_vld[2]), .dc_w_valid_i (w_vld[2]),
    .dc_r_ready_i (r_rdy_in[2]), .dc_b_ready_i (b_rdy_in[2]),
    .dc_ar_i (ar_pl[2]), .dc_aw_i (aw_pl[2]), .dc_w_i (w_pl[2]),
    .dc_ar_ready_o (ar_rdy[2]), .dc_aw_ready_o (aw_rdy[2]), .dc_w_ready_o (w_rdy[2]),
    .dc_r_valid_o (r_vld[2]), .dc_r_last_o (r_last[2]), .dc_b_valid_o (b_vld[2]),
    .dc_r_id_o (r_id[2]), .dc_b_id_o (b_id[2]), .dc_r_data_o (r_data[2]),
    .mem_ar_valid_o (mem_ar_valid_o), .mem_aw_valid_o (mem_aw_valid_o),
    .mem_w_valid_o (mem_w_valid_o), .mem_r_ready_o (mem_r_ready_o),
    .mem_b_ready_o (mem_b_ready_o), .mem_ar_o (mem_ar_o), .mem_aw_o (mem_aw_o),
    .mem_w_o (mem_w_o), .mem_ar_ready_i (mem_ar_rdy), .mem_aw_ready_i (mem_aw_rdy),
    .mem_w_ready_i (mem_w_rdy), .mem_r_valid_i (mem_r_vld), .mem_r_last_i (mem_r_lst),
    .mem_b_valid_i (mem_b_vld), .mem_r_id_i (mem_r_id), .mem_b_id_i (mem_b_id),
    .mem_r_data_i (mem_r_dat)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  // galois LFSR, one step per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  // one LFSR bit
  function automatic logic rand_bit();
    logic [31:0] v;
    v = lfsr_bits(1);
    return v[0];
  endfunction

  function automatic axi_lite_pkg::id_t id_of(input int s);
    return (s == 0) ? 4'b0000 : (s == 1) ? 4'b1010 : 4'b0111;
  endfunction

  // 0111 dcache, msb set bypass, rest icache
  function automatic int owner_of_id(input axi_lite_pkg::id_t id);
    return (id == 4'b0111) ? 2 : id[3] ? 1 : 0;
  endfunction

  function automatic axi_lite_pkg::id_t pick_resp_id();
    logic [2:0] k;
    k = 3'(lfsr_bits(3));
    case (k)
      3'd0, 3'd5: return 4'b0000;
      3'd1, 3'd6: return 4'b1010;
      3'd2, 3'd7: return 4'b0111;
      3'd3:       return 4'b1101; // memory side bypass ID
      default:    return 4'b0011;
    endcase
  endfunction

  function automatic axi_lite_pkg::addr_chan_t make_req(input int s);
    axi_lite_pkg::addr_chan_t a;
    a.id   = id_of(s);
    a.addr = lfsr_bits(32);
    a.len  = axi_lite_pkg::len_t'(lfsr_bits(2));
    return a;
  endfunction

  function automatic axi_lite_pkg::w_chan_t make_beat(input logic last);
    axi_lite_pkg::w_chan_t b;
    b.data = {lfsr_bits(32), lfsr_bits(32)};
    b.strb = axi_lite_pkg::strb_t'(lfsr_bits(8));
    b.last = last;
    return b;
  endfunction

  task automatic check(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("Fail at %0t: %s", $time, what);
    end
  endtask

  function automatic logic all_idle();
    return ar_vld == 3'b0 && aw_vld == 3'b0 && w_vld == 3'b0 && !mem_r_vld && !mem_b_vld
           && pend_len[0].size() == 0 && pend_len[1].size() == 0 && pend_len[2].size() == 0;
  endfunction

  task automatic drain();
    while (!all_idle()) @(posedge clk_i);
  endtask

  task automatic end_test(input int n, input string name);
    $display("test %0d %s finished, %0d errors so far", n, name, errors);
  endtask

  // ----------------------------------------
  // requester and memory models
  // ----------------------------------------
  always @(posedge clk_i) begin : drive
    if (rst_ni) begin
      for (int s = 0; s < 3; s++) begin
        if (ar_vld[s] && ar_rdy[s]) begin
          if (ar_keep) ar_pl[s] <= make_req(s);
          else ar_vld[s] <= 1'b0;
        end else if (!ar_vld[s] && ar_en[s] && rand_bit()) begin
          ar_vld[s] <= 1'b1;
          ar_pl[s]  <= make_req(s);
        end
        if (aw_vld[s] && aw_rdy[s]) begin
          pend_len[s].push_back(int'(aw_pl[s].len));
          aw_vld[s] <= 1'b0;
        end else if (!aw_vld[s] && aw_en[s] && rand_bit()) begin
          aw_vld[s] <= 1'b1;
          aw_pl[s]  <= make_req(s);
        end
        if (w_vld[s] && w_rdy[s]) begin
          beats_left[s]--;
          if (beats_left[s] == 0) begin
            void'(pend_len[s].pop_front());
            w_vld[s] <= 1'b0;
          end else w_pl[s] <= make_beat(beats_left[s] == 1);
        end else if (!w_vld[s] && !w_hold && pend_len[s].size() > 0 && rand_bit()) begin
          beats_left[s] = pend_len[s][0] + 1;
          w_vld[s] <= 1'b1;
          w_pl[s]  <= make_beat(beats_left[s] == 1);
        end
        r_rdy_in[s] <= rand_bit();
        b_rdy_in[s] <= rand_bit();
      end
      mem_ar_rdy <= rand_bit();
      mem_aw_rdy <= rand_bit();
      mem_w_rdy  <= rand_bit();
      if (mem_r_vld && mem_r_ready_o) mem_r_vld <= 1'b0;
      else if (!mem_r_vld && resp_en && rand_bit()) begin
        mem_r_vld <= 1'b1;
        mem_r_id  <= pick_resp_id();
        mem_r_dat <= {lfsr_bits(32), lfsr_bits(32)};
        mem_r_lst <= rand_bit();
      end
      if (mem_b_vld && mem_b_ready_o) mem_b_vld <= 1'b0;
      else if (!mem_b_vld && resp_en && rand_bit()) begin
        mem_b_vld <= 1'b1;
        mem_b_id  <= pick_resp_id();
      end
    end
  end

  // ----------------------------------------
  // checks, sampled mid-cycle
  // ----------------------------------------
  always @(negedge clk_i) begin : monitor
    int s;
    int h;
    logic ar_stall, aw_stall;
    axi_lite_pkg::addr_chan_t ar_held, aw_held;
    if (!rst_ni || phase == 1) begin
      check(!mem_ar_valid_o && !mem_aw_valid_o && !mem_w_valid_o && r_vld == 3'b0
            && b_vld == 3'b0, "valid output high around reset");
    end
    if (!rst_ni) begin
      ar_stall = 1'b0;
      aw_stall = 1'b0;
    end else begin
      if (wq.size() == `MUX_WFIFO_DEPTH) check(!mem_aw_valid_o, "mem AW offered while full");
      if (ar_stall) check(mem_ar_valid_o && mem_ar_o == ar_held, "mem AR changed in stall");
      if (aw_stall) check(mem_aw_valid_o && mem_aw_o == aw_held, "mem AW changed in stall");
      ar_stall = mem_ar_valid_o && !mem_ar_rdy;
      aw_stall = mem_aw_valid_o && !mem_aw_rdy;
      ar_held  = mem_ar_o;
      aw_held  = mem_aw_o;
      for (int k = 0; k < 3; k++) begin
        if (ar_vld[k] && ar_rdy[k]) req_ar_cnt[k]++;
        if (aw_vld[k] && aw_rdy[k]) req_aw_cnt[k]++;
        if (wq.size() > 0) begin
          if (k == wq[0]) check(w_rdy[k] == mem_w_rdy, "W ready to the head requester wrong");
          else check(!w_rdy[k], "W ready to a requester off turn");
        end
      end
      if (mem_ar_valid_o && mem_ar_rdy) begin
        s = owner_of_id(mem_ar_o.id);
        mem_ar_cnt[s]++;
        check(ar_vld[s] && ar_pl[s] == mem_ar_o, "mem AR differs from offered request");
        for (int k = 0; k < 3; k++) begin
          if (k == s) skip[k] = 0;
          else if (ar_vld[k]) skip[k]++;
          if (phase == 3) check(skip[k] <= `MUX_NUM_SRC - 1, "requester passed over");
        end
      end
      if (mem_w_valid_o && mem_w_rdy) begin
        if (wq.size() == 0) check(1'b0, "W beat with no write outstanding");
        else begin
          h = wq[0];
          check(w_vld[h] && w_pl[h] == mem_w_o, "mem W beat differs from queue head");
          if (mem_w_o.last) void'(wq.pop_front());
        end
      end
      if (mem_aw_valid_o && mem_aw_rdy) begin
        s = owner_of_id(mem_aw_o.id);
        mem_aw_cnt[s]++;
        check(aw_vld[s] && aw_pl[s] == mem_aw_o, "mem AW differs from offered request");
        wq.push_back(s);
      end
      if (mem_r_vld) begin
        h = owner_of_id(mem_r_id);
        for (int k = 0; k < 3; k++) begin
          check(r_vld[k] == (k == h) && (k != h || (r_id[k] == mem_r_id
                && r_data[k] == mem_r_dat && r_last[k] == mem_r_lst)), "R routed wrong");
        end
        check(mem_r_ready_o == r_rdy_in[h], "mem r_ready from wrong requester");
      end
      if (mem_b_vld) begin
        h = owner_of_id(mem_b_id);
        for (int k = 0; k < 3; k++) begin
          check(b_vld[k] == (k == h) && (k != h || b_id[k] == mem_b_id), "B routed wrong");
        end
        check(mem_b_ready_o == b_rdy_in[h], "mem b_ready from wrong requester");
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run stopped at the cycle limit of %0d, a test hung", CYCLE_LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    rst_ni <= 1'b0;
    {ar_vld, aw_vld, w_vld, r_rdy_in, b_rdy_in} <= '0;
    {mem_ar_rdy, mem_aw_rdy, mem_w_rdy, mem_r_vld, mem_r_lst, mem_b_vld} <= '0;
    mem_r_id <= '0;
    mem_b_id <= '0;
    mem_r_dat <= '0;
    for (int s = 0; s < 3; s++) begin
      ar_pl[s] <= '0;
      aw_pl[s] <= '0;
      w_pl[s]  <= '0;
      beats_left[s] = 0;
      {req_ar_cnt[s], mem_ar_cnt[s], req_aw_cnt[s], mem_aw_cnt[s], skip[s]} = '0;
    end
    {ar_en, aw_en, ar_keep, w_hold, resp_en} <= '0;
    phase <= 1;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (3) @(posedge clk_i);
    end_test(1, "reset");

    phase <= 2;
    ar_en <= 3'b111;
    repeat (400) @(posedge clk_i);
    ar_en <= 3'b000;
    drain();
    for (int s = 0; s < 3; s++) check(req_ar_cnt[s] == mem_ar_cnt[s], "AR count mismatch");
    end_test(2, "address transfer");

    phase   <= 3;
    ar_en   <= 3'b111;
    ar_keep <= 1'b1;
    repeat (200) @(posedge clk_i);
    ar_keep <= 1'b0;
    ar_en   <= 3'b000;
    drain();
    end_test(3, "fairness");

    phase  <= 4;
    w_hold <= 1'b1;
    aw_en  <= 3'b100;
    while (mem_aw_cnt[2] < `MUX_WFIFO_DEPTH) @(posedge clk_i);
    aw_en <= 3'b010;
    repeat (10) @(posedge clk_i);
    w_hold <= 1'b0;
    aw_en  <= 3'b111;
    repeat (300) @(posedge clk_i);
    aw_en <= 3'b000;
    drain();
    for (int s = 0; s < 3; s++) check(req_aw_cnt[s] == mem_aw_cnt[s], "AW count mismatch");
    end_test(4, "write order");

    phase   <= 5;
    resp_en <= 1'b1;
    repeat (300) @(posedge clk_i);
    resp_en <= 1'b0;
    drain();
    end_test(5, "response routing");

    $display("5 tests run, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* mem_port_mux.f */
+incdir+common
common/axi_lite_pkg.sv
common/port_pkg.sv
common/axi_bus_if.sv
source/stream_arbiter.sv
axi_mux/w_route_fifo.sv
axi_mux/resp_router.sv
axi_mux/mem_port_mux.sv
sim/tb_mem_port_mux.sv

/* Bender.yml */
package:
  name: mem_port_mux

export_include_dirs:
  - common

sources:
  - files:
      - common/axi_lite_pkg.sv
      - common/port_pkg.sv
      - common/axi_bus_if.sv
      - source/stream_arbiter.sv
      - axi_mux/w_route_fifo.sv
      - axi_mux/resp_router.sv
      - axi_mux/mem_port_mux.sv
  - target: simulation
    files:
      - sim/tb_mem_port_mux.sv
